// ==== build.f ====
common/jbi_err_pkg.sv
jbi_ncrd_timeout/jbi_ncrd_timeout.sv
jbi_j_par_chk/jbi_j_par_chk.sv
verilog/jbi_mout_csr.sv
verilog/jbi_csr_regs.sv
verilog/jbi_err_top.sv
tb/jbi_err_asserts.sv
tb/jbi_err_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the JBus error subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  -f build.f --top-module jbi_err_tb -o jbi_err_sim
out=$(./obj_dir/jbi_err_sim || true)
echo "$out"
echo "$out" | grep -q "Simulation passed"

// ==== tb/jbi_err_tb.sv ====
/*
 * Testbench for the JBus error and logging subsystem.
 * Runs a table of APB, JBus, alloc/free, NACK and injection steps.
 */
module jbi_err_tb import jbi_err_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [3:0] {
    st_write, st_read, st_jbus, st_alloc, st_free,
    st_wait, st_nack, st_no_nack, st_inj, st_irq
  } step_kind_t;

  // Data holds write data, a JBus sample, an ID or a cycle count.
  typedef struct packed {
    step_kind_t  kind;
    logic [4:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;    // Read data, NACK wait limit or mask.
    logic        flag;   // Pslverr, address cycle or irq level.
  } step_t;

  // Requests idle high, odd parity with jpar low.
  localparam jbus_ctl_t jbus_idle = {7'h7f, 12'h000, 1'b0};

  logic        clk;
  logic        arst_n;
  apb_req_t    apb;
  apb_rsp_t    apb_rsp;
  jbus_ctl_t   jbus;
  logic        alloc;
  jid_t        alloc_id;
  logic        free;
  jid_t        free_id;
  logic        addr_cycle;
  logic        data_cycle;
  logic        nack_valid;
  jid_t        nack_id;
  logic        nack_pop;
  logic [3:0]  inj_err_j_ad;
  logic        err_irq;
  step_t       steps[$];
  int unsigned max_cycles;
  int unsigned cycles;

  jbi_err_top #(
    .nack_depth (4)
  ) jbi_err_top_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .apb          (apb),
    .apb_rsp      (apb_rsp),
    .jbus         (jbus),
    .alloc        (alloc),
    .alloc_id     (alloc_id),
    .free         (free),
    .free_id      (free_id),
    .addr_cycle   (addr_cycle),
    .data_cycle   (data_cycle),
    .nack_valid   (nack_valid),
    .nack_id      (nack_id),
    .nack_pop     (nack_pop),
    .inj_err_j_ad (inj_err_j_ad),
    .err_irq      (err_irq)
  );

  always #50 clk = ~clk;

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Watchdog on the total run length.
  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("Timeout: the test did not finish within %0d cycles", max_cycles);
      stop_with_failure();
    end
  end

  task automatic check_rsp(apb_rsp_t exp);
    if (apb_rsp !== exp) begin
      $display("mismatch apb_rsp exp %h got %h at paddr %h", exp, apb_rsp, apb.paddr);
      stop_with_failure();
    end
  endtask

  task automatic check_nack(jid_t exp);
    if (nack_id !== exp) begin
      $display("mismatch nack_id exp %h got %h", exp, nack_id);
      stop_with_failure();
    end
  endtask

  task automatic check_inj(logic [3:0] exp);
    if (inj_err_j_ad !== exp) begin
      $display("mismatch inj_err_j_ad exp %h got %h", exp, inj_err_j_ad);
      stop_with_failure();
    end
  endtask

  task automatic check_irq(logic exp);
    if (err_irq !== exp) begin
      $display("mismatch err_irq exp %h got %h", exp, err_irq);
      stop_with_failure();
    end
  endtask

  // Inputs change 1 ns after the rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_inputs();
    apb        = '0;
    jbus       = jbus_idle;
    alloc      = 1'b0;
    alloc_id   = '0;
    free       = 1'b0;
    free_id    = '0;
    addr_cycle = 1'b0;
    data_cycle = 1'b0;
    nack_pop   = 1'b0;
  endtask

  // Setup cycle, then access cycle; the write lands at its closing edge.
  task automatic write_reg(logic [4:0] addr, logic [31:0] data);
    apb.psel   = 1'b1;
    apb.pwrite = 1'b1;
    apb.paddr  = addr;
    apb.pwdata = data;
    next_cycle();
    apb.penable = 1'b1;
    next_cycle();
    apb = '0;
  endtask

  // Read data is checked mid access cycle.
  task automatic read_reg(logic [4:0] addr, logic [31:0] exp_data, logic exp_err);
    apb_rsp_t exp;
    exp.prdata  = exp_data;
    exp.pslverr = exp_err;
    apb.psel  = 1'b1;
    apb.paddr = addr;
    next_cycle();
    apb.penable = 1'b1;
    @(negedge clk);
    check_rsp(exp);
    next_cycle();
    apb = '0;
  endtask

  // Wait for the head entry, check it, then pop it.
  task automatic expect_nack(jid_t id, int unsigned limit);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!nack_valid && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (!nack_valid) begin
      $display("No NACK for ID %h arrived within %0d cycles", id, limit);
      stop_with_failure();
    end
    check_nack(id);
    next_cycle();
    nack_pop = 1'b1;
    next_cycle();
    nack_pop = 1'b0;
  endtask

  task automatic run_step(step_t s);
    idle_inputs();
    case (s.kind)
      st_write: write_reg(s.addr, s.data);
      st_read:  read_reg(s.addr, s.exp, s.flag);
      st_jbus: begin
        jbus = jbus_ctl_t'(s.data[19:0]);
        next_cycle();
      end
      st_alloc: begin
        alloc    = 1'b1;
        alloc_id = s.data[3:0];
        next_cycle();
      end
      st_free: begin
        free    = 1'b1;
        free_id = s.data[3:0];
        next_cycle();
      end
      st_wait: repeat (s.data) next_cycle();
      st_nack: expect_nack(s.data[3:0], s.exp);
      st_no_nack: begin
        @(negedge clk);
        if (nack_valid) begin
          $display("Unexpected NACK for ID %h", nack_id);
          stop_with_failure();
        end
        next_cycle();
      end
      st_inj: begin
        addr_cycle = s.flag;
        data_cycle = ~s.flag;
        @(negedge clk);
        check_inj(s.exp[3:0]);
        next_cycle();
      end
      default: begin
        @(negedge clk);
        check_irq(s.flag);
        next_cycle();
      end
    endcase
  endtask

  function automatic void add_step(step_kind_t kind, logic [4:0] addr, logic [31:0] data,
                                   logic [31:0] exp, logic flag);
    step_t s;
    s.kind = kind;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    s.flag = flag;
    steps.push_back(s);
  endfunction

  // Legal random control, requests idle and random acknowledges.
  function automatic logic [18:0] random_rest();
    logic [31:0] r;
    r = $urandom;
    return {7'h7f, r[11:0]};
  endfunction

  // Good parity makes all 20 bits odd, bad parity makes them even.
  function automatic jbus_ctl_t make_sample(logic [18:0] rest, logic good);
    return good ? {rest, ~^rest} : {rest, ^rest};
  endfunction

  task automatic build_table();
    jbus_ctl_t   s1;
    jbus_ctl_t   s2;
    jbus_ctl_t   s3;
    jbus_ctl_t   p4;
    int unsigned total;
    s1 = make_sample(random_rest(), 1'b0);
    s2 = make_sample(random_rest(), 1'b0);
    s3 = make_sample(random_rest(), 1'b0);
    p4 = make_sample({7'h6f, 12'h000}, 1'b1);
    // Reset values and an unmapped offset.
    add_step(st_read, reg_status, '0, 32'h0, 1'b0);
    add_step(st_read, reg_log_enb, '0, 32'h0, 1'b0);
    add_step(st_read, reg_timeval, '0, 32'd64, 1'b0);
    add_step(st_read, reg_err_inject, '0, 32'h0, 1'b0);
    add_step(st_read, reg_log_par, '0, 32'h0, 1'b0);
    add_step(st_read, reg_port_present, '0, 32'h0, 1'b0);
    add_step(st_read, 5'h18, '0, 32'h0, 1'b1);
    // Written values read back.
    add_step(st_write, reg_timeval, 32'd8, '0, 1'b0);
    add_step(st_write, reg_log_enb, 32'h3, '0, 1'b0);
    add_step(st_write, reg_err_inject, 32'h1a, '0, 1'b0);
    add_step(st_read, reg_timeval, '0, 32'd8, 1'b0);
    add_step(st_read, reg_log_enb, '0, 32'h3, 1'b0);
    add_step(st_read, reg_err_inject, '0, 32'h1a, 1'b0);
    add_step(st_write, reg_log_enb, 32'h0, '0, 1'b0);
    // Timeout with logging off, then a freed ID, then logging on.
    // The long wait lets the tick counter reload from the new timeval.
    add_step(st_wait, '0, 32'd70, '0, 1'b0);
    add_step(st_alloc, '0, 32'h5, '0, 1'b0);
    add_step(st_nack, '0, 32'h5, 32'd18, 1'b0);
    add_step(st_read, reg_status, '0, 32'h0, 1'b0);
    add_step(st_irq, '0, '0, '0, 1'b0);
    add_step(st_write, reg_log_enb, 32'h1, '0, 1'b0);
    add_step(st_alloc, '0, 32'h3, '0, 1'b0);
    add_step(st_wait, '0, 32'd2, '0, 1'b0);
    add_step(st_free, '0, 32'h3, '0, 1'b0);
    add_step(st_wait, '0, 32'd30, '0, 1'b0);
    add_step(st_no_nack, '0, '0, '0, 1'b0);
    add_step(st_alloc, '0, 32'hb, '0, 1'b0);
    add_step(st_nack, '0, 32'hb, 32'd18, 1'b0);
    add_step(st_read, reg_status, '0, 32'h1, 1'b0);
    add_step(st_irq, '0, '0, '0, 1'b1);
    add_step(st_write, reg_status, 32'h1, '0, 1'b0);
    add_step(st_read, reg_status, '0, 32'h0, 1'b0);
    add_step(st_irq, '0, '0, '0, 1'b0);
    // Six timeouts against a four-entry queue, drained in ID order.
    for (int i = 0; i < 6; i++) begin
      add_step(st_alloc, '0, 32'(2 * i + 1), '0, 1'b0);
    end
    add_step(st_wait, '0, 32'd40, '0, 1'b0);
    for (int i = 0; i < 6; i++) begin
      add_step(st_nack, '0, 32'(2 * i + 1), 32'd4, 1'b0);
    end
    add_step(st_wait, '0, 32'd3, '0, 1'b0);
    add_step(st_no_nack, '0, '0, '0, 1'b0);
    // Parity on good samples, then first-error log capture.
    add_step(st_write, reg_status, 32'h3, '0, 1'b0);
    add_step(st_write, reg_log_enb, 32'h2, '0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      add_step(st_jbus, '0, {12'h0, make_sample(random_rest(), 1'b1)}, '0, 1'b0);
    end
    add_step(st_wait, '0, 32'd3, '0, 1'b0);
    add_step(st_read, reg_status, '0, 32'h0, 1'b0);
    add_step(st_jbus, '0, {12'h0, s1}, '0, 1'b0);
    add_step(st_wait, '0, 32'd3, '0, 1'b0);
    add_step(st_read, reg_status, '0, 32'h2, 1'b0);
    add_step(st_irq, '0, '0, '0, 1'b1);
    add_step(st_read, reg_log_par, '0, {1'b1, 11'h0, s1}, 1'b0);
    add_step(st_jbus, '0, {12'h0, s2}, '0, 1'b0);
    add_step(st_wait, '0, 32'd3, '0, 1'b0);
    add_step(st_read, reg_log_par, '0, {1'b1, 11'h0, s1}, 1'b0);
    add_step(st_write, reg_log_par, 32'h0, '0, 1'b0);
    add_step(st_read, reg_log_par, '0, {1'b0, 11'h0, s1}, 1'b0);
    add_step(st_jbus, '0, {12'h0, s3}, '0, 1'b0);
    add_step(st_wait, '0, 32'd3, '0, 1'b0);
    add_step(st_read, reg_log_par, '0, {1'b1, 11'h0, s3}, 1'b0);
    add_step(st_write, reg_status, 32'h2, '0, 1'b0);
    add_step(st_read, reg_status, '0, 32'h0, 1'b0);
    add_step(st_irq, '0, '0, '0, 1'b0);
    // Port 4 request seen low.
    add_step(st_jbus, '0, {12'h0, p4}, '0, 1'b0);
    add_step(st_wait, '0, 32'd3, '0, 1'b0);
    add_step(st_read, reg_port_present, '0, 32'h1, 1'b0);
    add_step(st_read, reg_status, '0, 32'h0, 1'b0);
    // Address cycle injection of mask 9, once only.
    add_step(st_write, reg_err_inject, 32'h39, '0, 1'b0);
    add_step(st_inj, '0, '0, 32'h0, 1'b0);
    add_step(st_inj, '0, '0, 32'h0, 1'b0);
    add_step(st_inj, '0, '0, 32'h9, 1'b1);
    add_step(st_inj, '0, '0, 32'h0, 1'b1);
    add_step(st_inj, '0, '0, 32'h0, 1'b0);
    add_step(st_inj, '0, '0, 32'h0, 1'b1);
    add_step(st_read, reg_err_inject, '0, 32'h19, 1'b0);
    total = 0;
    foreach (steps[i]) begin
      if (steps[i].kind == st_wait) begin
        total += steps[i].data;
      end else if (steps[i].kind == st_nack) begin
        total += steps[i].exp;
      end
    end
    max_cycles = total + 2000;
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    cycles     = 0;
    max_cycles = 2000;
    idle_inputs();
    void'($urandom(32'h8823ef13));
    build_table();
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== tb/jbi_err_asserts.sv ====
/*
 * Concurrent checks on the NACK queue head and the J_AD error injection.
 * Bound into the JBus output error block.
 */
module jbi_err_asserts import jbi_err_pkg::*; (
  input logic       clk,
  input logic       arst_n,
  input logic       nack_valid,
  input jid_t       nack_id,
  input logic       nack_pop,
  input logic       errtype,
  input logic       addr_cycle,
  input logic       data_cycle,
  input logic [3:0] inj_err_j_ad,
  input logic       inject_done
);
  timeunit 1ns;
  timeprecision 100ps;

  // Head of the NACK queue holds until it is popped.
  nack_hold: assert property (@(posedge clk) disable iff (!arst_n)
    nack_valid && !nack_pop |=> nack_valid && $stable(nack_id))
    else $error("nack_id changed while waiting for a pop");

  // No J_AD flip on a cycle of the wrong type.
  inj_type: assert property (@(posedge clk) disable iff (!arst_n)
    !(errtype ? addr_cycle : data_cycle) |-> inj_err_j_ad == 4'h0)
    else $error("inj_err_j_ad set on a cycle that does not match errtype");

  // Done pulse one cycle after an injection.
  inj_done: assert property (@(posedge clk) disable iff (!arst_n)
    inj_err_j_ad != 4'h0 |=> inject_done)
    else $error("inject_done missing after an injection");

endmodule

bind jbi_mout_csr jbi_err_asserts asserts_inst (
  .clk          (clk),
  .arst_n       (arst_n),
  .nack_valid   (nack_valid),
  .nack_id      (nack_id),
  .nack_pop     (nack_pop),
  .errtype      (cfg.errtype),
  .addr_cycle   (addr_cycle),
  .data_cycle   (data_cycle),
  .inj_err_j_ad (inj_err_j_ad),
  .inject_done  (inject_done)
);

// ==== verilog/jbi_err_top.sv ====
/*
 * JBus output port error and logging subsystem.
 * Joins the APB register file with the error block.
 */
module jbi_err_top import jbi_err_pkg::*; #(
  parameter int nack_depth = 4
) (
  input  logic       clk,
  input  logic       arst_n,
  input  apb_req_t   apb,
  output apb_rsp_t   apb_rsp,
  input  jbus_ctl_t  jbus,
  input  logic       alloc,
  input  jid_t       alloc_id,
  input  logic       free,
  input  jid_t       free_id,
  input  logic       addr_cycle,
  input  logic       data_cycle,
  output logic       nack_valid,
  output jid_t       nack_id,
  input  logic       nack_pop,
  output logic [3:0] inj_err_j_ad,
  output logic       err_irq
);

  csr_cfg_t cfg;
  err_evt_t evt;

  // Register side.
  jbi_csr_regs csr_regs_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .apb     (apb),
    .apb_rsp (apb_rsp),
    .evt     (evt),
    .cfg     (cfg),
    .err_irq (err_irq)
  );

  // Timeout, parity and injection.
  jbi_mout_csr #(
    .nack_depth (nack_depth)
  ) mout_csr_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .cfg          (cfg),
    .jbus         (jbus),
    .alloc        (alloc),
    .alloc_id     (alloc_id),
    .free         (free),
    .free_id      (free_id),
    .addr_cycle   (addr_cycle),
    .data_cycle   (data_cycle),
    .nack_valid   (nack_valid),
    .nack_id      (nack_id),
    .nack_pop     (nack_pop),
    .inj_err_j_ad (inj_err_j_ad),
    .evt          (evt)
  );

endmodule

// ==== verilog/jbi_csr_regs.sv ====
/*
 * JBus error CSR block.
 * APB register file with log enables, timeout value, error injection
 * control, W1C error status, the parity log view and the interrupt.
 */
module jbi_csr_regs import jbi_err_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  apb_req_t apb,
  output apb_rsp_t apb_rsp,
  input  err_evt_t evt,
  output csr_cfg_t cfg,
  output logic     err_irq
);

  logic        access;
  logic        mapped;
  logic        wr;
  logic [1:0]  status;
  logic [1:0]  status_set;
  logic [1:0]  status_clr;
  logic [1:0]  log_enb;
  logic [31:0] timeval;
  logic [3:0]  xormask;
  logic        errtype;
  logic        inject_output;
  logic        log_valid;
  par_log_t    log_q;

  // Access cycle of the APB transfer.
  assign access = apb.psel & apb.penable;

  always_comb begin
    case (apb.paddr)
      reg_status, reg_log_enb, reg_timeval,
      reg_err_inject, reg_log_par, reg_port_present: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  // Writes to unmapped offsets are dropped.
  assign wr = access & apb.pwrite & mapped;

  // Status bits only set when logging is enabled.
  assign status_set = {evt.cpar & log_enb[1], evt.read_to & log_enb[0]};
  assign status_clr = (wr && apb.paddr == reg_status) ? apb.pwdata[1:0] : 2'b00;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      status        <= 2'b00;
      log_enb       <= 2'b00;
      timeval       <= 32'd64;
      xormask       <= 4'h0;
      errtype       <= 1'b0;
      inject_output <= 1'b0;
    end else begin
      // Hardware set wins over a W1C in the same cycle.
      status <= (status & ~status_clr) | status_set;
      if (wr && apb.paddr == reg_log_enb) begin
        log_enb <= apb.pwdata[1:0];
      end
      if (wr && apb.paddr == reg_timeval) begin
        timeval <= apb.pwdata;
      end
      if (wr && apb.paddr == reg_err_inject) begin
        xormask <= apb.pwdata[3:0];
        errtype <= apb.pwdata[4];
      end
      // Done from the injector drops the request bit.
      if (evt.inject_done) begin
        inject_output <= 1'b0;
      end else if (wr && apb.paddr == reg_err_inject) begin
        inject_output <= apb.pwdata[5];
      end
    end
  end

  // First-error parity log, held until software writes log_par.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      log_valid <= 1'b0;
      log_q     <= '0;
    end else if (evt.cpar && !log_valid) begin
      log_valid <= 1'b1;
      log_q     <= evt.log;
    end else if (wr && apb.paddr == reg_log_par) begin
      log_valid <= 1'b0;
    end
  end

  // Read data mux.
  always_comb begin
    case (apb.paddr)
      reg_status:       apb_rsp.prdata = {30'b0, status};
      reg_log_enb:      apb_rsp.prdata = {30'b0, log_enb};
      reg_timeval:      apb_rsp.prdata = timeval;
      reg_err_inject:   apb_rsp.prdata = {26'b0, inject_output, errtype, xormask};
      reg_log_par:      apb_rsp.prdata = {log_valid, 11'b0, log_q};
      reg_port_present: apb_rsp.prdata = {30'b0, evt.port5_present, evt.port4_present};
      default:          apb_rsp.prdata = 32'h0;
    endcase
  end

  assign apb_rsp.pslverr = access & ~mapped;

  assign cfg.timeval       = timeval;
  assign cfg.enb_read_to   = log_enb[0];
  assign cfg.enb_cpar      = log_enb[1];
  assign cfg.xormask       = xormask;
  assign cfg.errtype       = errtype;
  assign cfg.inject_output = inject_output;

  // Interrupt while any error is logged.
  assign err_irq = |status;

endmodule

// ==== verilog/jbi_mout_csr.sv ====
/*
 * JBus output error block.
 * Read timeout tracking, J_PAR checking and J_AD error injection.
 */
module jbi_mout_csr import jbi_err_pkg::*; #(
  parameter int nack_depth = 4
) (
  input  logic      clk,
  input  logic      arst_n,
  input  csr_cfg_t  cfg,
  input  jbus_ctl_t jbus,
  input  logic      alloc,
  input  jid_t      alloc_id,
  input  logic      free,
  input  jid_t      free_id,
  input  logic      addr_cycle,
  input  logic      data_cycle,
  output logic      nack_valid,
  output jid_t      nack_id,
  input  logic      nack_pop,
  output logic [3:0] inj_err_j_ad,
  output err_evt_t  evt
);

  logic     read_to;
  logic     cpar;
  par_log_t log;
  logic     port4_present;
  logic     port5_present;
  logic     inject_output_q;
  logic     set_req;
  logic     err_req;
  logic     type_match;
  logic     inject_now;
  logic     inject_done;

  jbi_ncrd_timeout #(
    .nack_depth (nack_depth)
  ) ncrd_timeout_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .alloc      (alloc),
    .alloc_id   (alloc_id),
    .free       (free),
    .free_id    (free_id),
    .timeval    (cfg.timeval),
    .nack_valid (nack_valid),
    .nack_id    (nack_id),
    .nack_pop   (nack_pop),
    .read_to    (read_to)
  );

  jbi_j_par_chk j_par_chk_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .jbus          (jbus),
    .cpar          (cpar),
    .log           (log),
    .port4_present (port4_present),
    .port5_present (port5_present)
  );

  // Rising edge of the inject bit arms one request.
  assign set_req = cfg.inject_output & ~inject_output_q;

  // Errtype 1 selects address cycles.
  assign type_match = cfg.errtype ? addr_cycle : data_cycle;
  assign inject_now = err_req & type_match;

  // Flip the chosen J_AD bits on this cycle only.
  assign inj_err_j_ad = cfg.xormask & {4{inject_now}};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      inject_output_q <= 1'b0;
      err_req         <= 1'b0;
      inject_done     <= 1'b0;
    end else begin
      inject_output_q <= cfg.inject_output;
      err_req         <= (err_req & ~inject_now) | set_req;
      inject_done     <= inject_now;   // Clears the CSR bit next edge.
    end
  end

  assign evt.read_to       = read_to;
  assign evt.cpar          = cpar;
  assign evt.inject_done   = inject_done;
  assign evt.port4_present = port4_present;
  assign evt.port5_present = port5_present;
  assign evt.log           = log;

endmodule

// ==== jbi_j_par_chk/jbi_j_par_chk.sv ====
/*
 * JBus control parity checker.
 * Samples the request and acknowledge lines with J_PAR, checks odd
 * parity, logs the failing sample and tracks port 4 and 5 presence.
 */
module jbi_j_par_chk import jbi_err_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  jbus_ctl_t jbus,
  output logic      cpar,
  output par_log_t  log,
  output logic      port4_present,
  output logic      port5_present
);

  jbus_ctl_t jbus_q;
  logic      par_err;

  // Sample the control lines.
  // Requests idle high, which also gives odd parity out of reset.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      jbus_q        <= '0;
      jbus_q.jreq_l <= 7'h7f;
    end else begin
      jbus_q <= jbus;
    end
  end

  // J_PAR makes the 20 sampled bits odd.
  assign par_err = ~(^jbus_q);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cpar <= 1'b0;
    end else begin
      cpar <= par_err;
    end
  end

  // Failing sample, valid with cpar.
  always_ff @(posedge clk) begin
    if (par_err) begin
      log <= par_log_t'(jbus_q);
    end
  end

  // Port present is sticky once its request is seen asserted.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      port4_present <= 1'b0;
      port5_present <= 1'b0;
    end else begin
      port4_present <= port4_present | ~jbus_q.jreq_l[4];
      port5_present <= port5_present | ~jbus_q.jreq_l[5];
    end
  end

endmodule

// ==== jbi_ncrd_timeout/jbi_ncrd_timeout.sv ====
/*
 * Read transaction timeout tracker.
 * Ages each outstanding ID on a shared tick and queues a NACK
 * for every ID that times out.
 */
module jbi_ncrd_timeout import jbi_err_pkg::*; #(
  parameter int nack_depth = 4
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        alloc,
  input  jid_t        alloc_id,
  input  logic        free,
  input  jid_t        free_id,
  input  logic [31:0] timeval,
  output logic        nack_valid,
  output jid_t        nack_id,
  input  logic        nack_pop,
  output logic        read_to
);

  localparam int num_id = 1 << jid_w;
  localparam int ptr_w  = (nack_depth > 1) ? $clog2(nack_depth) : 1;
  localparam int cnt_w  = $clog2(nack_depth + 1);

  logic [31:0]       tick_cnt;
  logic              tick;
  logic [num_id-1:0] outstanding;
  logic [1:0]        age [num_id];
  logic              any_to;
  jid_t              to_id;
  logic              push;
  logic              pop;
  logic              full;
  jid_t              fifo [nack_depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  count;

  // Shared tick, once every timeval cycles.
  assign tick = (tick_cnt == 32'd0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt <= 32'd0;
    end else if (tick) begin
      tick_cnt <= (timeval == 32'd0) ? 32'd0 : timeval - 32'd1;
    end else begin
      tick_cnt <= tick_cnt - 32'd1;
    end
  end

  // Lowest outstanding ID whose age reached 2.
  always_comb begin
    any_to = 1'b0;
    to_id  = '0;
    for (int i = num_id - 1; i >= 0; i--) begin
      if (outstanding[i] && age[i][1]) begin
        any_to = 1'b1;
        to_id  = jid_t'(i);
      end
    end
  end

  // A full queue leaves the ID pending; it is retried next cycle.
  assign full = (count == cnt_w'(nack_depth));
  assign push = any_to & ~full;
  assign pop  = nack_pop & nack_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= '0;
      for (int i = 0; i < num_id; i++) begin
        age[i] <= 2'd0;
      end
    end else begin
      for (int i = 0; i < num_id; i++) begin
        if (alloc && alloc_id == jid_t'(i)) begin
          outstanding[i] <= 1'b1;
          age[i]         <= 2'd0;
        end else if ((free && free_id == jid_t'(i)) || (push && to_id == jid_t'(i))) begin
          outstanding[i] <= 1'b0;
        end else if (tick && outstanding[i] && !age[i][1]) begin
          age[i] <= age[i] + 2'd1;   // Saturates at 2.
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      read_to <= 1'b0;
    end else begin
      read_to <= push;
    end
  end

  // NACK queue storage.
  always_ff @(posedge clk) begin
    if (push) begin
      fifo[wr_ptr] <= to_id;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(nack_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(nack_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(push) - cnt_w'(pop);
    end
  end

  // Head of queue stays put until popped.
  assign nack_valid = (count != '0);
  assign nack_id    = fifo[rd_ptr];

endmodule

// ==== common/jbi_err_pkg.sv ====
/*
 * JBus error and logging package.
 * Shared types for the APB register block, the read timeout tracker,
 * the J_PAR checker and the error injection control.
 */
package jbi_err_pkg;

  // Transaction ID width, 16 IDs.
  localparam int jid_w = 4;

  typedef logic [jid_w-1:0] jid_t;

  // One cycle of sampled JBus control lines.
  typedef struct packed {
    logic [6:0] jreq_l;   // Active-low request lines.
    logic [2:0] jpack0;
    logic [2:0] jpack1;
    logic [2:0] jpack4;
    logic [2:0] jpack5;
    logic       jpar;
  } jbus_ctl_t;

  // Snapshot of the control lines at the first parity error.
  typedef struct packed {
    logic [6:0] jreq_l;
    logic [2:0] jpack0;
    logic [2:0] jpack1;
    logic [2:0] jpack4;
    logic [2:0] jpack5;
    logic       jpar;
  } par_log_t;

  // APB request, zero wait state bus.
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  // Configuration from the register file to the error block.
  typedef struct packed {
    logic [31:0] timeval;
    logic        enb_read_to;
    logic        enb_cpar;
    logic [3:0]  xormask;
    logic        errtype;        // 1 = address cycle, 0 = data cycle.
    logic        inject_output;
  } csr_cfg_t;

  // Events from the error block back to the register file.
  typedef struct packed {
    logic     read_to;
    logic     cpar;
    logic     inject_done;
    logic     port4_present;
    logic     port5_present;
    par_log_t log;
  } err_evt_t;

  // Register offsets.
  localparam logic [4:0] reg_status       = 5'h00;
  localparam logic [4:0] reg_log_enb      = 5'h04;
  localparam logic [4:0] reg_timeval      = 5'h08;
  localparam logic [4:0] reg_err_inject   = 5'h0C;
  localparam logic [4:0] reg_log_par      = 5'h10;
  localparam logic [4:0] reg_port_present = 5'h14;

endpackage
